// File: hdl/cache_wb_pkg.sv
// cache write-back sizes
// word, block and address widths seen on the cache side
package cache_wb_pkg;

  localparam int num_cache_c   = 4;
  localparam int word_width_c  = 32;
  localparam int block_words_c = 8;
  localparam int addr_width_c  = 32;

  // derived widths
  localparam int cache_idx_width_c = (num_cache_c > 1) ? $clog2(num_cache_c) : 1;
  localparam int word_idx_width_c  = (block_words_c > 1) ? $clog2(block_words_c) : 1;

  typedef logic [cache_idx_width_c-1:0] cache_idx_t;
  typedef logic [word_width_c-1:0]      word_t;
  typedef logic [addr_width_c-1:0]      wb_addr_t;

endpackage

// File: hdl/axi_wr_pkg.sv
// AXI write side sizes
// beat width, packing ratio and the fixed burst encoding
package axi_wr_pkg;
  import cache_wb_pkg::*;

  localparam int axi_data_width_c = 64;
  localparam int axi_strb_width_c = axi_data_width_c / 8;
  localparam int pack_ratio_c     = axi_data_width_c / word_width_c; // words per beat
  localparam int burst_len_c      = block_words_c / pack_ratio_c;    // one burst per block

  // fixed AW fields
  localparam logic [7:0] axi_awlen_c      = 8'(burst_len_c - 1);
  localparam logic [2:0] axi_awsize_c     = 3'($clog2(axi_strb_width_c));
  localparam logic [1:0] axi_burst_incr_c = 2'b01;

  typedef logic [axi_data_width_c-1:0] axi_beat_t;
  typedef logic [1:0]                  axi_resp_t;

endpackage

// File: hdl/small_fifo.sv
// small synchronous FIFO
// circular buffer with a typed payload, pops on yumi
`timescale 1ns/1ps

module small_fifo #(
  parameter int  els_p     = 4,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  payload_t                mem [els_p];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    push;

  assign ready_o = (count_r != cnt_width_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem[rd_ptr_r];
  assign push    = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (yumi_i) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + cnt_width_lp'(push) - cnt_width_lp'(yumi_i);
    end
  end

endmodule

// File: hdl/wb_steer.sv
// write-back steering
// routes the shared word stream to the buffer of the tagged cache
`timescale 1ns/1ps

module wb_steer import cache_wb_pkg::*; #(
  parameter int num_cache_p   = num_cache_c,
  parameter int block_words_p = block_words_c
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   wb_v_i,
  input  cache_idx_t             wb_cache_i,
  input  wb_addr_t               wb_addr_i,
  input  word_t                  wb_data_i,
  output logic                   wb_ready_o,
  output logic [num_cache_p-1:0] fill_v_o,
  output word_t                  fill_data_o,
  output logic                   fill_last_o,
  output wb_addr_t               fill_addr_o,
  input  logic [num_cache_p-1:0] fill_ready_i
);

  localparam int cnt_width_lp = (block_words_p > 1) ? $clog2(block_words_p) : 1;

  logic [cnt_width_lp-1:0] word_cnt_r;
  wb_addr_t                addr_r;
  logic                    accept;

  always_comb begin
    fill_v_o             = '0;
    fill_v_o[wb_cache_i] = wb_v_i;
  end

  assign wb_ready_o  = fill_ready_i[wb_cache_i];
  assign accept      = wb_v_i & wb_ready_o;
  assign fill_data_o = wb_data_i;
  assign fill_last_o = (word_cnt_r == cnt_width_lp'(block_words_p - 1));
  assign fill_addr_o = (word_cnt_r == '0) ? wb_addr_i : addr_r; // single word blocks too

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      word_cnt_r <= '0;
    end else if (accept) begin
      word_cnt_r <= fill_last_o ? '0 : word_cnt_r + 1'b1;
    end
  end

  // block address rides on the first word
  always_ff @(posedge clk_i) begin
    if (accept && (word_cnt_r == '0)) addr_r <= wb_addr_i;
  end

endmodule

// File: hdl/cache_wb_buffer.sv
// per-cache block buffer
// fills one block, requests the bus once full, then drains to the transmitter
`timescale 1ns/1ps

module cache_wb_buffer import cache_wb_pkg::*; #(
  parameter int block_words_p = block_words_c
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     fill_v_i,
  input  word_t    fill_data_i,
  input  logic     fill_last_i,
  input  wb_addr_t fill_addr_i,
  output logic     fill_ready_o,
  output logic     req_o,
  output wb_addr_t blk_addr_o,
  input  logic     grant_i,
  output word_t    dma_data_o,
  output logic     dma_v_o,
  input  logic     dma_yumi_i
);

  typedef enum logic [1:0] {
    st_fill,
    st_wait,
    st_drain
  } state_e;

  state_e   state_r;
  logic     fifo_ready;
  logic     fifo_v;
  logic     push;
  wb_addr_t blk_addr_r;

  small_fifo #(
    .els_p    (block_words_p),
    .payload_t(word_t)
  ) u_data_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .v_i    (push),
    .data_i (fill_data_i),
    .ready_o(fifo_ready),
    .v_o    (fifo_v),
    .data_o (dma_data_o),
    .yumi_i (dma_yumi_i)
  );

  assign fill_ready_o = (state_r == st_fill) & fifo_ready;
  assign push         = fill_v_i & fill_ready_o;
  assign req_o        = (state_r == st_wait);
  assign dma_v_o      = (state_r == st_drain) & fifo_v;
  assign blk_addr_o   = blk_addr_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= st_fill;
    end else begin
      case (state_r)
        st_fill:  if (push && fill_last_i) state_r <= st_wait;
        st_wait:  if (grant_i) state_r <= st_drain;
        st_drain: if (!fifo_v) state_r <= st_fill; // block fully sent
        default:  state_r <= st_fill;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && fill_last_i) blk_addr_r <= fill_addr_i;
  end

endmodule

// File: hdl/wb_arbiter.sv
// round-robin arbiter over the full block buffers
// holds its pick stable until the address handshake completes
`timescale 1ns/1ps

module wb_arbiter import cache_wb_pkg::*; #(
  parameter int num_cache_p = num_cache_c
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [num_cache_p-1:0] req_i,
  input  wb_addr_t               blk_addr_i [num_cache_p],
  output logic                   v_o,
  output cache_idx_t             tag_o,
  output wb_addr_t               addr_o,
  input  logic                   yumi_i,
  output logic [num_cache_p-1:0] grant_o
);

  cache_idx_t last_r;
  cache_idx_t lock_tag_r;
  cache_idx_t pick;
  logic       lock_r;
  logic       found;

  // search starts one past the last grant
  always_comb begin
    int idx;
    pick  = last_r;
    found = 1'b0;
    for (int off = 1; off <= num_cache_p; off++) begin
      idx = (int'(last_r) + off) % num_cache_p;
      if (!found && req_i[idx]) begin
        pick  = cache_idx_t'(idx);
        found = 1'b1;
      end
    end
  end

  assign v_o    = found;
  assign tag_o  = lock_r ? lock_tag_r : pick;
  assign addr_o = blk_addr_i[tag_o];

  always_comb begin
    grant_o        = '0;
    grant_o[tag_o] = yumi_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_r     <= cache_idx_t'(num_cache_p - 1); // first search begins at cache 0
      lock_r     <= 1'b0;
      lock_tag_r <= '0;
    end else if (yumi_i) begin
      last_r <= tag_o;
      lock_r <= 1'b0;
    end else if (v_o) begin
      lock_r     <= 1'b1; // awvalid up without awready
      lock_tag_r <= tag_o;
    end
  end

endmodule

// File: hdl/axi_wr_tx.sv
// AXI write transmitter
// one INCR burst per block, packs cache words into beats, watches bresp
`timescale 1ns/1ps

module axi_wr_tx import cache_wb_pkg::*, axi_wr_pkg::*; #(
  parameter int num_cache_p      = num_cache_c,
  parameter int word_width_p     = word_width_c,
  parameter int block_words_p    = block_words_c,
  parameter int axi_data_width_p = axi_data_width_c
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        v_i,
  input  cache_idx_t                  tag_i,
  input  wb_addr_t                    addr_i,
  output logic                        yumi_o,
  input  word_t                       dma_data_i [num_cache_p],
  input  logic [num_cache_p-1:0]      dma_v_i,
  output logic [num_cache_p-1:0]      dma_yumi_o,
  output wb_addr_t                    awaddr_o,
  output logic                        awvalid_o,
  input  logic                        awready_i,
  output logic [axi_data_width_p-1:0] wdata_o,
  output logic                        wvalid_o,
  output logic                        wlast_o,
  input  logic                        wready_i,
  input  logic                        bvalid_i,
  input  axi_resp_t                   bresp_i,
  output logic                        bready_o,
  output logic                        err_o
);

  localparam int pack_ratio_lp     = axi_data_width_p / word_width_p;
  localparam int burst_len_lp      = block_words_p / pack_ratio_lp;
  localparam int pack_cnt_width_lp = $clog2(pack_ratio_lp + 1);
  localparam int word_cnt_width_lp = (block_words_p > 1) ? $clog2(block_words_p) : 1;
  localparam int beat_cnt_width_lp = (burst_len_lp > 1) ? $clog2(burst_len_lp) : 1;

  cache_idx_t                   head_tag;
  logic                         tag_v;
  logic                         tag_pop;
  word_t                        head_word;
  logic                         pop_word;
  logic                         w_fire;
  logic [pack_cnt_width_lp-1:0] pack_cnt_r;
  logic [word_cnt_width_lp-1:0] word_cnt_r;
  logic [beat_cnt_width_lp-1:0] beat_cnt_r;
  logic [axi_data_width_p-1:0]  beat_r;
  logic                         bready_r;
  logic                         err_r;

  // address channel
  assign yumi_o    = v_i & awready_i;
  assign awvalid_o = v_i;
  assign awaddr_o  = addr_i;

  // at most one block per cache in flight, so the tag queue never fills
  small_fifo #(
    .els_p    (num_cache_p),
    .payload_t(cache_idx_t)
  ) u_tag_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .v_i    (yumi_o),
    .data_i (tag_i),
    .ready_o(),
    .v_o    (tag_v),
    .data_o (head_tag),
    .yumi_i (tag_pop)
  );

  assign head_word = dma_data_i[head_tag];
  assign wvalid_o  = (pack_cnt_r == pack_cnt_width_lp'(pack_ratio_lp)); // beat complete
  assign pop_word  = tag_v & dma_v_i[head_tag] & ~wvalid_o;
  assign tag_pop   = pop_word & (word_cnt_r == word_cnt_width_lp'(block_words_p - 1));
  assign w_fire    = wvalid_o & wready_i;
  assign wlast_o   = wvalid_o & (beat_cnt_r == beat_cnt_width_lp'(burst_len_lp - 1));
  assign wdata_o   = beat_r;

  always_comb begin
    dma_yumi_o           = '0;
    dma_yumi_o[head_tag] = pop_word;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pack_cnt_r <= '0;
      word_cnt_r <= '0;
      beat_cnt_r <= '0;
    end else begin
      if (w_fire) begin
        pack_cnt_r <= '0;
      end else if (pop_word) begin
        pack_cnt_r <= pack_cnt_r + 1'b1;
      end
      if (pop_word) begin
        word_cnt_r <= tag_pop ? '0 : word_cnt_r + 1'b1;
      end
      if (w_fire) begin
        beat_cnt_r <= wlast_o ? '0 : beat_cnt_r + 1'b1;
      end
    end
  end

  // first word lands in the low bits
  always_ff @(posedge clk_i) begin
    if (pop_word) beat_r[pack_cnt_r*word_width_p +: word_width_p] <= head_word;
  end

  // response channel, always accepting
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bready_r <= 1'b0;
      err_r    <= 1'b0;
    end else begin
      bready_r <= 1'b1;
      if (bvalid_i && bready_r && (bresp_i != 2'b00)) err_r <= 1'b1; // sticky
    end
  end

  assign bready_o = bready_r;
  assign err_o    = err_r;

endmodule

// File: hdl/cache_to_axi_wr.sv
// cache write-back to AXI write port
// steer, per-cache block buffers, round-robin arbiter and AXI transmitter
`timescale 1ns/1ps

module cache_to_axi_wr import cache_wb_pkg::*, axi_wr_pkg::*; #(
  parameter int num_cache_p      = num_cache_c,
  parameter int word_width_p     = word_width_c,
  parameter int block_words_p    = block_words_c,
  parameter int axi_data_width_p = axi_data_width_c
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        wb_v_i,
  input  cache_idx_t                  wb_cache_i,
  input  wb_addr_t                    wb_addr_i,
  input  word_t                       wb_data_i,
  output logic                        wb_ready_o,
  output wb_addr_t                    awaddr_o,
  output logic                        awvalid_o,
  input  logic                        awready_i,
  output logic [axi_data_width_p-1:0] wdata_o,
  output logic                        wvalid_o,
  output logic                        wlast_o,
  input  logic                        wready_i,
  input  logic                        bvalid_i,
  input  axi_resp_t                   bresp_i,
  output logic                        bready_o,
  output logic                        err_o
);

  logic [num_cache_p-1:0] fill_v;
  logic [num_cache_p-1:0] fill_ready;
  word_t                  fill_data;
  logic                   fill_last;
  wb_addr_t               fill_addr;
  logic [num_cache_p-1:0] req;
  logic [num_cache_p-1:0] grant;
  wb_addr_t               blk_addr [num_cache_p];
  word_t                  dma_data [num_cache_p];
  logic [num_cache_p-1:0] dma_v;
  logic [num_cache_p-1:0] dma_yumi;
  logic                   arb_v;
  cache_idx_t             arb_tag;
  wb_addr_t               arb_addr;
  logic                   arb_yumi;

  wb_steer #(
    .num_cache_p  (num_cache_p),
    .block_words_p(block_words_p)
  ) u_wb_steer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_v_i      (wb_v_i),
    .wb_cache_i  (wb_cache_i),
    .wb_addr_i   (wb_addr_i),
    .wb_data_i   (wb_data_i),
    .wb_ready_o  (wb_ready_o),
    .fill_v_o    (fill_v),
    .fill_data_o (fill_data),
    .fill_last_o (fill_last),
    .fill_addr_o (fill_addr),
    .fill_ready_i(fill_ready)
  );

  for (genvar i = 0; i < num_cache_p; i++) begin : g_buf
    cache_wb_buffer #(
      .block_words_p(block_words_p)
    ) u_cache_wb_buffer (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .fill_v_i    (fill_v[i]),
      .fill_data_i (fill_data),
      .fill_last_i (fill_last),
      .fill_addr_i (fill_addr),
      .fill_ready_o(fill_ready[i]),
      .req_o       (req[i]),
      .blk_addr_o  (blk_addr[i]),
      .grant_i     (grant[i]),
      .dma_data_o  (dma_data[i]),
      .dma_v_o     (dma_v[i]),
      .dma_yumi_i  (dma_yumi[i])
    );
  end

  wb_arbiter #(
    .num_cache_p(num_cache_p)
  ) u_wb_arbiter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (req),
    .blk_addr_i(blk_addr),
    .v_o       (arb_v),
    .tag_o     (arb_tag),
    .addr_o    (arb_addr),
    .yumi_i    (arb_yumi),
    .grant_o   (grant)
  );

  axi_wr_tx #(
    .num_cache_p     (num_cache_p),
    .word_width_p    (word_width_p),
    .block_words_p   (block_words_p),
    .axi_data_width_p(axi_data_width_p)
  ) u_axi_wr_tx (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .v_i       (arb_v),
    .tag_i     (arb_tag),
    .addr_i    (arb_addr),
    .yumi_o    (arb_yumi),
    .dma_data_i(dma_data),
    .dma_v_i   (dma_v),
    .dma_yumi_o(dma_yumi),
    .awaddr_o  (awaddr_o),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .wdata_o   (wdata_o),
    .wvalid_o  (wvalid_o),
    .wlast_o   (wlast_o),
    .wready_i  (wready_i),
    .bvalid_i  (bvalid_i),
    .bresp_i   (bresp_i),
    .bready_o  (bready_o),
    .err_o     (err_o)
  );

endmodule

// File: test/cache_to_axi_wr_assert.sv
// AXI write channel protocol checks
// bound into the top level, address and data hold under back-pressure
`timescale 1ns/1ps

module cache_to_axi_wr_assert import cache_wb_pkg::*, axi_wr_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input wb_addr_t  awaddr_o,
  input logic      awvalid_o,
  input logic      awready_i,
  input axi_beat_t wdata_o,
  input logic      wvalid_o,
  input logic      wlast_o,
  input logic      wready_i
);

  int         fail_cnt = 0;
  logic [7:0] beat_cnt_r;

  // accepted beats within the current burst
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      beat_cnt_r <= '0;
    end else if (wvalid_o && wready_i) begin
      beat_cnt_r <= (beat_cnt_r == axi_awlen_c) ? '0 : beat_cnt_r + 1'b1;
    end
  end

  aw_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
    else begin
      $error("awaddr_o changed or awvalid_o dropped before awready_i");
      fail_cnt++;
    end

  w_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wlast_o))
    else begin
      $error("wdata_o changed or wvalid_o dropped before wready_i");
      fail_cnt++;
    end

  wlast_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wvalid_o || wlast_o) |-> wvalid_o && (wlast_o == (beat_cnt_r == axi_awlen_c)))
    else begin
      $error("wlast_o without wvalid_o or not on the last beat of a burst");
      fail_cnt++;
    end

endmodule

// File: test/tb_cache_to_axi_wr.sv
// testbench for the cache write-back to AXI write path
// table-driven block stimulus, AXI slave model with random ready, checks per block group
`timescale 1ns/1ps

module tb_cache_to_axi_wr import cache_wb_pkg::*, axi_wr_pkg::*; ();

  typedef struct packed {
    cache_idx_t cache;
    wb_addr_t   addr;
    word_t      seed;
    axi_resp_t  bresp;
    logic [3:0] stall;    // awready low cycles after the group is filled, at least 1
    logic       grp_end;  // last block filled before awready is released
    logic       rand_rdy;
  } entry_t;

  localparam int num_ent_lp = 12;

  // round-robin group 4..6 fills cache 0 first, since it holds the address bus
  entry_t tbl [num_ent_lp] = '{
    '{2'd0, 32'h1000_0040, 32'h0000_0100, 2'b00, 4'd3, 1'b1, 1'b0},
    '{2'd1, 32'h2000_0080, 32'h1100_0000, 2'b00, 4'd3, 1'b1, 1'b0},
    '{2'd2, 32'h3000_00c0, 32'h2200_0000, 2'b00, 4'd3, 1'b1, 1'b0},
    '{2'd3, 32'h4000_0100, 32'h3300_0000, 2'b00, 4'd3, 1'b1, 1'b0},
    '{2'd0, 32'h5000_0000, 32'h4400_0010, 2'b00, 4'd6, 1'b0, 1'b0},
    '{2'd3, 32'h5000_0200, 32'h4400_0020, 2'b00, 4'd6, 1'b0, 1'b0},
    '{2'd1, 32'h5000_0400, 32'h4400_0030, 2'b00, 4'd6, 1'b1, 1'b0},
    '{2'd1, 32'h6000_0000, 32'h5500_0000, 2'b00, 4'd2, 1'b0, 1'b1},
    '{2'd3, 32'h6000_1000, 32'h5500_1000, 2'b00, 4'd2, 1'b0, 1'b1},
    '{2'd2, 32'h6000_2000, 32'h5500_2000, 2'b00, 4'd2, 1'b1, 1'b1},
    '{2'd0, 32'h7000_0000, 32'h6600_0000, 2'b10, 4'd1, 1'b1, 1'b1},
    '{2'd2, 32'h7100_0000, 32'h7700_0000, 2'b00, 4'd1, 1'b1, 1'b1}
  };

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  logic       wb_v_i;
  cache_idx_t wb_cache_i;
  wb_addr_t   wb_addr_i;
  word_t      wb_data_i;
  logic       wb_ready_o;
  wb_addr_t   awaddr_o;
  logic       awvalid_o;
  logic       awready_i = 1'b0;
  axi_beat_t  wdata_o;
  logic       wvalid_o;
  logic       wlast_o;
  logic       wready_i = 1'b0;
  logic       bvalid_i = 1'b0;
  axi_resp_t  bresp_i = 2'b00;
  logic       bready_o;
  logic       err_o;

  // slave model state
  int         seed = 32'h4578;
  logic       aw_hold;
  logic       rand_rdy;
  logic       b_due = 1'b0;
  axi_resp_t  cur_bresp = 2'b00;
  int         burst_cnt = 0;
  int         b_cnt = 0;
  wb_addr_t   aw_q [$];
  axi_beat_t  beat_q [$];
  logic       last_q [$];
  axi_resp_t  bresp_q [$];
  int         errors = 0;

  cache_to_axi_wr #(
    .num_cache_p     (num_cache_c),
    .word_width_p    (word_width_c),
    .block_words_p   (block_words_c),
    .axi_data_width_p(axi_data_width_c)
  ) u_cache_to_axi_wr (.*);

  bind cache_to_axi_wr cache_to_axi_wr_assert u_axi_assert (.*);

  always #5 clk_i = ~clk_i;

  // ready and response drive, 1 ns after the edge
  always @(posedge clk_i) begin
    logic [31:0] r;
    #1;
    r = $random(seed);
    awready_i = !aw_hold && (!rand_rdy || r[0]);
    wready_i  = !rand_rdy || r[1];
    bvalid_i  = b_due;
    bresp_i   = cur_bresp;
  end

  // monitor at the falling edge where all channels are stable
  always @(negedge clk_i) begin
    b_due = 1'b0;
    if (rst_n_i) begin
      if (awvalid_o && awready_i) aw_q.push_back(awaddr_o);
      if (wvalid_o && wready_i) begin
        beat_q.push_back(wdata_o);
        last_q.push_back(wlast_o);
        if (wlast_o) begin
          b_due     = 1'b1;
          cur_bresp = bresp_q[burst_cnt];
          burst_cnt++;
        end
      end
      if (bvalid_i && bready_o) b_cnt++;
    end
  end

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // one block on the shared stream, words are seed plus index
  task automatic write_block(input cache_idx_t c, input wb_addr_t addr, input word_t first);
    int tries;
    for (int w = 0; w < block_words_c; w++) begin
      #1;
      wb_v_i     = 1'b1;
      wb_cache_i = c;
      wb_addr_i  = addr;
      wb_data_i  = first + word_t'(w);
      tries      = 0;
      @(negedge clk_i);
      while (!wb_ready_o) begin
        if (tries > 500) abort_run("write-back port never became ready");
        tries++;
        @(negedge clk_i);
      end
      @(posedge clk_i);
    end
  endtask

  initial begin
    int        tries;
    int        c;
    int        idx;
    int        g_first;
    int        t_err;
    int        n_tests;
    int        n_failed;
    int        last_grant;
    int        aw_base;
    int        beat_base;
    int        b_base;
    logic      exp_err;
    axi_beat_t exp_beat;
    int        ord [$];

    wb_v_i     = 1'b0;
    wb_cache_i = '0;
    wb_addr_i  = '0;
    wb_data_i  = '0;
    rst_n_i    = 1'b0;
    aw_hold    = 1'b1;
    rand_rdy   = 1'b0;
    n_tests    = 0;
    n_failed   = 0;
    last_grant = num_cache_c - 1;
    exp_err    = 1'b0;

    repeat (2) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    t_err = errors;
    check_hex("awvalid_o", awvalid_o, 1'b0);
    check_hex("wvalid_o", wvalid_o, 1'b0);
    check_hex("wlast_o", wlast_o, 1'b0);
    check_hex("err_o", err_o, 1'b0);
    check_hex("bready_o", bready_o, 1'b1);
    check_hex("wb_ready_o", wb_ready_o, 1'b1);
    $display("test %0d: state after reset, %s", n_tests, (errors == t_err) ? "pass" : "fail");
    n_failed += (errors != t_err);
    n_tests++;

    g_first = 0;
    for (int e = 0; e < num_ent_lp; e++) begin
      if (e == g_first) begin
        @(posedge clk_i);
        aw_hold   = 1'b1;
        rand_rdy  = tbl[e].rand_rdy;
        aw_base   = aw_q.size();
        beat_base = beat_q.size();
        b_base    = b_cnt;
        t_err     = errors;
      end
      write_block(tbl[e].cache, tbl[e].addr, tbl[e].seed);
      if (tbl[e].grp_end) begin
        // round-robin order, starting after the last granted cache
        ord.delete();
        for (int off = 1; off <= num_cache_c; off++) begin
          c = (last_grant + off) % num_cache_c;
          for (int k = g_first; k <= e; k++) begin
            if (int'(tbl[k].cache) == c) ord.push_back(k);
          end
        end
        last_grant = int'(tbl[ord[ord.size()-1]].cache);
        foreach (ord[i]) begin
          bresp_q.push_back(tbl[ord[i]].bresp);
          if (tbl[ord[i]].bresp != 2'b00) exp_err = 1'b1;
        end
        #1 wb_v_i = 1'b0;
        repeat (int'(tbl[e].stall)) @(posedge clk_i);
        @(negedge clk_i);
        check_hex("awvalid_o", awvalid_o, 1'b1);
        aw_hold = 1'b0;

        tries = 0;
        while ((beat_q.size() - beat_base < ord.size() * burst_len_c) ||
               (b_cnt - b_base < ord.size())) begin
          if (tries > 2000) abort_run("bursts or write responses did not complete");
          tries++;
          @(posedge clk_i);
        end
        @(negedge clk_i);

        check_hex("aw count", aw_q.size() - aw_base, ord.size());
        foreach (ord[i]) begin
          check_hex("awaddr_o", aw_q[aw_base + i], tbl[ord[i]].addr);
          for (int k = 0; k <= int'(axi_awlen_c); k++) begin
            idx = beat_base + i * burst_len_c + k;
            for (int j = 0; j < pack_ratio_c; j++) begin
              exp_beat[j*word_width_c +: word_width_c] =
                tbl[ord[i]].seed + word_t'(k * pack_ratio_c + j);
            end
            check_hex("wdata_o", beat_q[idx], exp_beat);
            check_hex("wlast_o", last_q[idx], k == int'(axi_awlen_c));
          end
        end
        check_hex("err_o", err_o, exp_err);
        $display("test %0d: %0d block(s), last grant %0d, rand ready %0d, %s", n_tests,
                 ord.size(), last_grant, rand_rdy, (errors == t_err) ? "pass" : "fail");
        n_failed += (errors != t_err);
        n_tests++;
        g_first = e + 1;
      end
    end

    // sticky error only clears on reset
    t_err = errors;
    @(posedge clk_i);
    #1 rst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_hex("err_o", err_o, 1'b0);
    check_hex("bready_o", bready_o, 1'b1);
    if (u_cache_to_axi_wr.u_axi_assert.fail_cnt != 0) begin
      $display("bound AXI assertions failed %0d times", u_cache_to_axi_wr.u_axi_assert.fail_cnt);
      errors++;
    end
    $display("test %0d: err_o cleared by reset, %s", n_tests, (errors == t_err) ? "pass" : "fail");
    n_failed += (errors != t_err);
    n_tests++;

    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: src.f
hdl/cache_wb_pkg.sv
hdl/axi_wr_pkg.sv
hdl/small_fifo.sv
hdl/wb_steer.sv
hdl/cache_wb_buffer.sv
hdl/wb_arbiter.sv
hdl/axi_wr_tx.sv
hdl/cache_to_axi_wr.sv
test/cache_to_axi_wr_assert.sv
test/tb_cache_to_axi_wr.sv

// File: Makefile
TOP = tb_cache_to_axi_wr

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

obj_dir/V$(TOP): src.f $(wildcard hdl/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
